// File: project.f
rtl/dispatch_pkg.sv
rtl/dispatch_stage_reg.sv
rtl/operand_fetch.sv
rtl/hazard_check.sv
rtl/issue_control.sv
rtl/dispatch_top.sv
testbench/tb_dispatch.sv

// File: rtl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int NUM_UNITS  = 6;

  // --------------------------------------------------------------------------
  // vector types
  // --------------------------------------------------------------------------
  typedef logic [XLEN-1:0]       xlen_t;     // operands, pcs, immediates, targets
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // register n sits in slice n of the flat vector
  typedef logic [NUM_REGS*XLEN-1:0] reg_file_t;

  typedef logic [NUM_UNITS-1:0] unit_mask_t; // bit index is the unit_e value

  // one register index per unit, unit u in slice u
  typedef logic [NUM_UNITS*REG_ADDR_W-1:0] unit_regs_t;

  // execution unit class delivered by the decoder
  typedef enum logic [2:0] {
    UNIT_ALU = 3'd0,
    UNIT_MPU = 3'd1,
    UNIT_DVU = 3'd2,
    UNIT_LSU = 3'd3,
    UNIT_CSU = 3'd4,
    UNIT_BRU = 3'd5
  } unit_e;

endpackage

`default_nettype wire

// File: rtl/dispatch_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage_reg (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   freeze,
  input  wire logic                   flush,

  input  wire logic                   idu_vld,
  input  wire dispatch_pkg::unit_e     idu_unit,
  input  wire dispatch_pkg::xlen_t     idu_pc,
  input  wire dispatch_pkg::xlen_t     idu_imm,
  input  wire dispatch_pkg::reg_addr_t idu_rs1,
  input  wire dispatch_pkg::reg_addr_t idu_rs2,
  input  wire dispatch_pkg::reg_addr_t idu_rd,
  input  wire logic                   idu_br_taken,
  input  wire dispatch_pkg::xlen_t     idu_pred_pc,

  output logic                        dpu_vld,
  output dispatch_pkg::unit_e         dpu_unit,
  output dispatch_pkg::xlen_t         dpu_pc,
  output dispatch_pkg::xlen_t         dpu_imm,
  output dispatch_pkg::reg_addr_t     dpu_rs1,
  output dispatch_pkg::reg_addr_t     dpu_rs2,
  output dispatch_pkg::reg_addr_t     dpu_rd,
  output logic                        dpu_br_taken,
  output dispatch_pkg::xlen_t         dpu_pred_pc
);

  logic hold;
  logic capture;

  // a held instruction that is frozen blocks the decoder
  assign hold    = dpu_vld & freeze;
  assign capture = idu_vld & ~hold & ~flush;

  // --------------------------------------------------------------------------
  // valid bit
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dpu_vld <= 1'b0;
    end
    else if (flush)
    begin
      dpu_vld <= 1'b0;  // flush wins over a capture in the same cycle
    end
    else if (capture)
    begin
      dpu_vld <= 1'b1;
    end
    else if (hold)
    begin
      dpu_vld <= 1'b1;
    end
    else
    begin
      dpu_vld <= 1'b0;  // issued and nothing new behind it
    end
  end

  // --------------------------------------------------------------------------
  // instruction fields, loaded only on capture
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      dpu_unit     <= idu_unit;
      dpu_pc       <= idu_pc;
      dpu_imm      <= idu_imm;
      dpu_rs1      <= idu_rs1;
      dpu_rs2      <= idu_rs2;
      dpu_rd       <= idu_rd;
      dpu_br_taken <= idu_br_taken;  // prediction is only carried along
      dpu_pred_pc  <= idu_pred_pc;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
  input  wire logic                    clk,
  input  wire logic                    rst,

  // decoder side
  input  wire logic                    idu_vld,
  input  wire dispatch_pkg::unit_e      idu_unit,
  input  wire dispatch_pkg::xlen_t      idu_pc,
  input  wire dispatch_pkg::xlen_t      idu_imm,
  input  wire dispatch_pkg::reg_addr_t  idu_rs1,
  input  wire dispatch_pkg::reg_addr_t  idu_rs2,
  input  wire dispatch_pkg::reg_addr_t  idu_rd,
  input  wire logic                    idu_br_taken,
  input  wire dispatch_pkg::xlen_t      idu_pred_pc,

  input  wire dispatch_pkg::reg_file_t  reg_file,

  // in-flight instructions of the execution units
  input  wire dispatch_pkg::unit_mask_t unit_busy,
  input  wire dispatch_pkg::unit_regs_t unit_rs1,
  input  wire dispatch_pkg::unit_regs_t unit_rs2,
  input  wire dispatch_pkg::unit_regs_t unit_rd,

  // execute stage
  input  wire logic                    exu_vld,
  input  wire logic                    exu_freeze,
  input  wire logic                    exu_br_miss,
  input  wire logic                    exu_trap,
  input  wire dispatch_pkg::reg_addr_t  exu_rs1,
  input  wire dispatch_pkg::reg_addr_t  exu_rs2,
  input  wire dispatch_pkg::reg_addr_t  exu_rd,

  output logic                         dpu_vld,
  output logic                         dpu_freeze,
  output dispatch_pkg::unit_mask_t     issue_vld,
  output dispatch_pkg::unit_e          dpu_unit,
  output dispatch_pkg::xlen_t          dpu_pc,
  output dispatch_pkg::xlen_t          dpu_imm,
  output dispatch_pkg::reg_addr_t      dpu_rs1,
  output dispatch_pkg::reg_addr_t      dpu_rs2,
  output dispatch_pkg::reg_addr_t      dpu_rd,
  output logic                         dpu_br_taken,
  output dispatch_pkg::xlen_t          dpu_pred_pc,
  output dispatch_pkg::xlen_t          dpu_rs1_data,
  output dispatch_pkg::xlen_t          dpu_rs2_data,
  output dispatch_pkg::xlen_t          target_jal,
  output dispatch_pkg::xlen_t          target_branch,
  output dispatch_pkg::xlen_t          target_jalr
);

  logic flush;
  logic hazard;

  dispatch_stage_reg stage_reg_i (
    .clk          (clk),
    .rst          (rst),
    .freeze       (dpu_freeze),
    .flush        (flush),
    .idu_vld      (idu_vld),
    .idu_unit     (idu_unit),
    .idu_pc       (idu_pc),
    .idu_imm      (idu_imm),
    .idu_rs1      (idu_rs1),
    .idu_rs2      (idu_rs2),
    .idu_rd       (idu_rd),
    .idu_br_taken (idu_br_taken),
    .idu_pred_pc  (idu_pred_pc),
    .dpu_vld      (dpu_vld),
    .dpu_unit     (dpu_unit),
    .dpu_pc       (dpu_pc),
    .dpu_imm      (dpu_imm),
    .dpu_rs1      (dpu_rs1),
    .dpu_rs2      (dpu_rs2),
    .dpu_rd       (dpu_rd),
    .dpu_br_taken (dpu_br_taken),
    .dpu_pred_pc  (dpu_pred_pc)
  );

  // operands and targets follow the held instruction in the same cycle
  operand_fetch operand_fetch_i (
    .reg_file      (reg_file),
    .rs1           (dpu_rs1),
    .rs2           (dpu_rs2),
    .pc            (dpu_pc),
    .imm           (dpu_imm),
    .rs1_data      (dpu_rs1_data),
    .rs2_data      (dpu_rs2_data),
    .target_jal    (target_jal),
    .target_branch (target_branch),
    .target_jalr   (target_jalr)
  );

  hazard_check hazard_check_i (
    .rs1       (dpu_rs1),
    .rs2       (dpu_rs2),
    .rd        (dpu_rd),
    .unit_busy (unit_busy),
    .unit_rs1  (unit_rs1),
    .unit_rs2  (unit_rs2),
    .unit_rd   (unit_rd),
    .exu_vld   (exu_vld),
    .exu_rs1   (exu_rs1),
    .exu_rs2   (exu_rs2),
    .exu_rd    (exu_rd),
    .hazard    (hazard)
  );

  issue_control issue_control_i (
    .dpu_vld     (dpu_vld),
    .dpu_unit    (dpu_unit),
    .hazard      (hazard),
    .exu_vld     (exu_vld),
    .exu_freeze  (exu_freeze),
    .exu_br_miss (exu_br_miss),
    .exu_trap    (exu_trap),
    .freeze      (dpu_freeze),  // also the back-pressure seen by the decoder
    .flush       (flush),
    .issue_vld   (issue_vld)
  );

endmodule

`default_nettype wire

// File: rtl/hazard_check.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_check (
  input  wire dispatch_pkg::reg_addr_t  rs1,
  input  wire dispatch_pkg::reg_addr_t  rs2,
  input  wire dispatch_pkg::reg_addr_t  rd,

  input  wire dispatch_pkg::unit_mask_t unit_busy,
  input  wire dispatch_pkg::unit_regs_t unit_rs1,
  input  wire dispatch_pkg::unit_regs_t unit_rs2,
  input  wire dispatch_pkg::unit_regs_t unit_rd,

  input  wire logic                    exu_vld,
  input  wire dispatch_pkg::reg_addr_t  exu_rs1,
  input  wire dispatch_pkg::reg_addr_t  exu_rs2,
  input  wire dispatch_pkg::reg_addr_t  exu_rd,

  output logic                         hazard
);

  localparam int RW = dispatch_pkg::REG_ADDR_W;

  // one dispatch field against all three fields of one source, x0 never conflicts
  function automatic logic field_hit(
    input dispatch_pkg::reg_addr_t field,
    input dispatch_pkg::reg_addr_t src_rs1,
    input dispatch_pkg::reg_addr_t src_rs2,
    input dispatch_pkg::reg_addr_t src_rd
  );
    return (field != '0) &&
           ((field == src_rs1) || (field == src_rs2) || (field == src_rd));
  endfunction

  function automatic logic source_hit(
    input dispatch_pkg::reg_addr_t src_rs1,
    input dispatch_pkg::reg_addr_t src_rs2,
    input dispatch_pkg::reg_addr_t src_rd
  );
    return field_hit(rs1, src_rs1, src_rs2, src_rd) |
           field_hit(rs2, src_rs1, src_rs2, src_rd) |
           field_hit(rd,  src_rs1, src_rs2, src_rd);
  endfunction

  always_comb
  begin
    hazard = exu_vld & source_hit(exu_rs1, exu_rs2, exu_rd);
    for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++)
    begin
      hazard |= unit_busy[u] &
                source_hit(unit_rs1[u*RW +: RW], unit_rs2[u*RW +: RW], unit_rd[u*RW +: RW]);
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_control.sv
`timescale 1ns/1ps
`default_nettype none

module issue_control (
  input  wire logic                   dpu_vld,
  input  wire dispatch_pkg::unit_e     dpu_unit,
  input  wire logic                   hazard,
  input  wire logic                   exu_vld,
  input  wire logic                   exu_freeze,
  input  wire logic                   exu_br_miss,
  input  wire logic                   exu_trap,

  output logic                        freeze,
  output logic                        flush,
  output dispatch_pkg::unit_mask_t    issue_vld
);

  logic go;

  // --------------------------------------------------------------------------
  // stall and flush
  // --------------------------------------------------------------------------

  // execute can stall the stage even while nothing is held
  assign freeze = (dpu_vld & hazard) | (exu_vld & exu_freeze);

  // a mispredicted branch or a trap kills whatever sits in dispatch
  assign flush = exu_vld & (exu_br_miss | exu_trap);

  // --------------------------------------------------------------------------
  // issue
  // --------------------------------------------------------------------------
  assign go = dpu_vld & ~freeze & ~flush;

  // the class compare leaves the mask one-hot, or zero when not issuing
  always_comb
  begin
    for (int u = 0; u < dispatch_pkg::NUM_UNITS; u++)
    begin
      issue_vld[u] = go && (dpu_unit == dispatch_pkg::unit_e'(u));
    end
  end

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
  input  wire dispatch_pkg::reg_file_t reg_file,
  input  wire dispatch_pkg::reg_addr_t rs1,
  input  wire dispatch_pkg::reg_addr_t rs2,
  input  wire dispatch_pkg::xlen_t     pc,
  input  wire dispatch_pkg::xlen_t     imm,

  output dispatch_pkg::xlen_t         rs1_data,
  output dispatch_pkg::xlen_t         rs2_data,
  output dispatch_pkg::xlen_t         target_jal,
  output dispatch_pkg::xlen_t         target_branch,
  output dispatch_pkg::xlen_t         target_jalr
);

  localparam int XLEN = dispatch_pkg::XLEN;

  dispatch_pkg::xlen_t imm_j;
  dispatch_pkg::xlen_t imm_b;
  dispatch_pkg::xlen_t imm_i;
  dispatch_pkg::xlen_t jalr_sum;

  // NUM_REGS-way read port on the flat register vector
  function automatic dispatch_pkg::xlen_t read_reg(
    input dispatch_pkg::reg_file_t regs,
    input dispatch_pkg::reg_addr_t idx
  );
    return regs[idx*XLEN +: XLEN];
  endfunction

  assign rs1_data = read_reg(reg_file, rs1);
  assign rs2_data = read_reg(reg_file, rs2);

  // --------------------------------------------------------------------------
  // target candidates
  // --------------------------------------------------------------------------
  assign imm_j = {{(XLEN-21){imm[20]}}, imm[20:0]};
  assign imm_b = {{(XLEN-13){imm[12]}}, imm[12:0]};
  assign imm_i = {{(XLEN-12){imm[11]}}, imm[11:0]};

  assign target_jal    = pc + imm_j;
  assign target_branch = pc + imm_b;

  assign jalr_sum    = rs1_data + imm_i;
  assign target_jalr = {jalr_sum[XLEN-1:1], 1'b0};  // jalr always lands halfword aligned

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_dispatch --Mdir "$BUILD_DIR" -o tb_dispatch
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$BUILD_DIR/tb_dispatch" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

exit 0

// File: testbench/tb_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;

  localparam int XLEN         = dispatch_pkg::XLEN;
  localparam int NREGS        = dispatch_pkg::NUM_REGS;
  localparam int NU           = dispatch_pkg::NUM_UNITS;
  localparam int IDLE_TIMEOUT = 20;

  // one cycle of stimulus plus the expected control response
  typedef struct packed {
    logic                     vld;
    dispatch_pkg::unit_e      unit;
    dispatch_pkg::xlen_t      pc;
    dispatch_pkg::xlen_t      imm;
    dispatch_pkg::reg_addr_t  rs1;
    dispatch_pkg::reg_addr_t  rs2;
    dispatch_pkg::reg_addr_t  rd;
    dispatch_pkg::unit_mask_t busy;
    dispatch_pkg::reg_addr_t  src_rs;      // rs1 and rs2 of every busy unit and of execute
    dispatch_pkg::reg_addr_t  src_rd;
    logic [3:0]               exu;         // vld, freeze, br_miss, trap
    logic                     exp_vld;
    logic                     exp_freeze;
    dispatch_pkg::unit_mask_t exp_issue;
  } row_t;

  logic                     clk;
  logic                     rst;
  logic                     idu_vld;
  dispatch_pkg::unit_e      idu_unit;
  dispatch_pkg::xlen_t      idu_pc;
  dispatch_pkg::xlen_t      idu_imm;
  dispatch_pkg::reg_addr_t  idu_rs1;
  dispatch_pkg::reg_addr_t  idu_rs2;
  dispatch_pkg::reg_addr_t  idu_rd;
  logic                     idu_br_taken;
  dispatch_pkg::xlen_t      idu_pred_pc;
  dispatch_pkg::reg_file_t  reg_file;
  dispatch_pkg::unit_mask_t unit_busy;
  dispatch_pkg::unit_regs_t unit_rs1;
  dispatch_pkg::unit_regs_t unit_rs2;
  dispatch_pkg::unit_regs_t unit_rd;
  logic                     exu_vld;
  logic                     exu_freeze;
  logic                     exu_br_miss;
  logic                     exu_trap;
  dispatch_pkg::reg_addr_t  exu_rs1;
  dispatch_pkg::reg_addr_t  exu_rs2;
  dispatch_pkg::reg_addr_t  exu_rd;

  logic                     dpu_vld;
  logic                     dpu_freeze;
  dispatch_pkg::unit_mask_t issue_vld;
  dispatch_pkg::unit_e      dpu_unit;
  dispatch_pkg::xlen_t      dpu_pc;
  dispatch_pkg::xlen_t      dpu_imm;
  dispatch_pkg::reg_addr_t  dpu_rs1;
  dispatch_pkg::reg_addr_t  dpu_rs2;
  dispatch_pkg::reg_addr_t  dpu_rd;
  logic                     dpu_br_taken;
  dispatch_pkg::xlen_t      dpu_pred_pc;
  dispatch_pkg::xlen_t      dpu_rs1_data;
  dispatch_pkg::xlen_t      dpu_rs2_data;
  dispatch_pkg::xlen_t      target_jal;
  dispatch_pkg::xlen_t      target_branch;
  dispatch_pkg::xlen_t      target_jalr;

  dispatch_pkg::xlen_t      reg_vals [NREGS];
  row_t                     rows [$];

  dispatch_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // --------------------------------------------------------------------------
  // reference helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0])
    begin
      nxt = nxt ^ 32'hA300_0000;
    end
    return nxt;
  endfunction

  // copy bit msb into every bit above it
  function automatic dispatch_pkg::xlen_t sext(input dispatch_pkg::xlen_t v, input int msb);
    dispatch_pkg::xlen_t r;
    r = v;
    for (int i = msb + 1; i < XLEN; i++)
    begin
      r[i] = v[msb];
    end
    return r;
  endfunction

  task automatic fill_regs();
    logic [31:0] lfsr;
    lfsr = 32'd54;
    for (int r = 0; r < NREGS; r++)
    begin
      for (int b = 0; b < XLEN; b++)
      begin
        reg_vals[r][b] = lfsr[0];  // one step for every bit taken
        lfsr = lfsr_next(lfsr);
      end
      reg_file[r*XLEN +: XLEN] = reg_vals[r];
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic add_row(
    input logic v, input dispatch_pkg::unit_e u, input logic [31:0] pc, input logic [31:0] imm,
    input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd, input logic [5:0] busy,
    input logic [4:0] src_rs, input logic [4:0] src_rd, input logic [3:0] exu,
    input logic xv, input logic xf, input logic [5:0] xi
  );
    rows.push_back('{v, u, pc, imm, rs1, rs2, rd, busy, src_rs, src_rd, exu, xv, xf, xi});
  endtask

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    // routing through all six classes with nothing busy
    add_row(1'b1, dispatch_pkg::UNIT_ALU, 32'h0000_1000, 32'h001f_f801, 5'd1, 5'd2, 5'd3,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b0, 1'b0, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_MPU, 32'h0000_1004, 32'h000e_e7ff, 5'd4, 5'd5, 5'd6,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b000001);
    add_row(1'b1, dispatch_pkg::UNIT_DVU, 32'h0000_1008, 32'h0010_0800, 5'd7, 5'd8, 5'd9,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b000010);
    add_row(1'b1, dispatch_pkg::UNIT_LSU, 32'h0000_100c, 32'h0000_1000, 5'd10, 5'd11, 5'd12,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b000100);
    add_row(1'b1, dispatch_pkg::UNIT_CSU, 32'h0000_1010, 32'hffff_f7fe, 5'd13, 5'd14, 5'd15,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b001000);
    add_row(1'b1, dispatch_pkg::UNIT_BRU, 32'h0000_1014, 32'h0000_0ffd, 5'd31, 5'd30, 5'd29,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b010000);
    add_row(1'b0, dispatch_pkg::UNIT_ALU, 32'h0000_0000, 32'h0000_0000, 5'd0, 5'd0, 5'd0,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b100000);
    // hazard hold on a busy mpu whose rd is the held rs1
    add_row(1'b1, dispatch_pkg::UNIT_ALU, 32'h0000_2000, 32'h0000_0123, 5'd7, 5'd8, 5'd9,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b0, 1'b0, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_LSU, 32'h0000_2100, 32'h001f_f004, 5'd0, 5'd10, 5'd0,
            6'b000010, 5'd20, 5'd7, 4'b0000, 1'b1, 1'b1, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_LSU, 32'h0000_2100, 32'h001f_f004, 5'd0, 5'd10, 5'd0,
            6'b000010, 5'd20, 5'd7, 4'b0000, 1'b1, 1'b1, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_LSU, 32'h0000_2100, 32'h001f_f004, 5'd0, 5'd10, 5'd0,
            6'b000000, 5'd20, 5'd7, 4'b0000, 1'b1, 1'b0, 6'b000001);
    // x0 fields of the held lsu meet x0 fields in every busy unit
    add_row(1'b0, dispatch_pkg::UNIT_ALU, 32'h0000_0000, 32'h0000_0000, 5'd0, 5'd0, 5'd0,
            6'b111111, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b001000);
    // execute stall, then branch miss and trap flushes
    add_row(1'b1, dispatch_pkg::UNIT_DVU, 32'h0000_4000, 32'h0000_0800, 5'd12, 5'd13, 5'd14,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b0, 1'b0, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_BRU, 32'h0000_4100, 32'h000f_f7f0, 5'd15, 5'd16, 5'd17,
            6'b000000, 5'd0, 5'd0, 4'b1100, 1'b1, 1'b1, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_BRU, 32'h0000_4100, 32'h000f_f7f0, 5'd15, 5'd16, 5'd17,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b1, 1'b0, 6'b000100);
    add_row(1'b1, dispatch_pkg::UNIT_ALU, 32'h0000_4200, 32'h0010_1801, 5'd18, 5'd19, 5'd20,
            6'b000000, 5'd0, 5'd0, 4'b1010, 1'b1, 1'b0, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_ALU, 32'h0000_4200, 32'h0010_1801, 5'd18, 5'd19, 5'd20,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b0, 1'b0, 6'b000000);
    add_row(1'b1, dispatch_pkg::UNIT_MPU, 32'h0000_4300, 32'h0000_0002, 5'd21, 5'd22, 5'd23,
            6'b000000, 5'd0, 5'd0, 4'b1001, 1'b1, 1'b0, 6'b000000);
    add_row(1'b0, dispatch_pkg::UNIT_ALU, 32'h0000_0000, 32'h0000_0000, 5'd0, 5'd0, 5'd0,
            6'b000000, 5'd0, 5'd0, 4'b0000, 1'b0, 1'b0, 6'b000000);
  endtask

  task automatic drive_row(input row_t r);
    idu_vld      = r.vld;
    idu_unit     = r.unit;
    idu_pc       = r.pc;
    idu_imm      = r.imm;
    idu_rs1      = r.rs1;
    idu_rs2      = r.rs2;
    idu_rd       = r.rd;
    idu_br_taken = r.pc[3];
    idu_pred_pc  = r.pc + 32'd4;
    unit_busy    = r.busy;
    unit_rs1     = {NU{r.src_rs}};
    unit_rs2     = {NU{r.src_rs}};
    unit_rd      = {NU{r.src_rd}};
    {exu_vld, exu_freeze, exu_br_miss, exu_trap} = r.exu;
    exu_rs1      = r.src_rs;
    exu_rs2      = r.src_rs;
    exu_rd       = r.src_rd;
  endtask

  // h is the instruction the stage should be holding
  task automatic check_row(input row_t r, input row_t h);
    dispatch_pkg::xlen_t jalr_sum;
    check_val("dpu_vld", 32'(dpu_vld), 32'(r.exp_vld));
    check_val("dpu_freeze", 32'(dpu_freeze), 32'(r.exp_freeze));
    check_val("issue_vld", 32'(issue_vld), 32'(r.exp_issue));
    if (r.exp_vld)
    begin
      jalr_sum = reg_vals[h.rs1] + sext(h.imm, 11);
      check_val("dpu_unit", 32'(dpu_unit), 32'(h.unit));
      check_val("dpu_pc", dpu_pc, h.pc);
      check_val("dpu_imm", dpu_imm, h.imm);
      check_val("dpu_rs1", 32'(dpu_rs1), 32'(h.rs1));
      check_val("dpu_rs2", 32'(dpu_rs2), 32'(h.rs2));
      check_val("dpu_rd", 32'(dpu_rd), 32'(h.rd));
      check_val("dpu_br_taken", 32'(dpu_br_taken), 32'(h.pc[3]));
      check_val("dpu_pred_pc", dpu_pred_pc, h.pc + 32'd4);
      check_val("dpu_rs1_data", dpu_rs1_data, reg_vals[h.rs1]);
      check_val("dpu_rs2_data", dpu_rs2_data, reg_vals[h.rs2]);
      check_val("target_jal", target_jal, h.pc + sext(h.imm, 20));
      check_val("target_branch", target_branch, h.pc + sext(h.imm, 12));
      check_val("target_jalr", target_jalr, jalr_sum & ~32'd1);
    end
  endtask

  task automatic wait_idle(input string where);
    int cycles;
    cycles = 0;
    while ((dpu_vld !== 1'b0 || issue_vld !== '0) && cycles < IDLE_TIMEOUT)
    begin
      @(negedge clk);
      #2;
      cycles++;
    end
    if (dpu_vld !== 1'b0 || issue_vld !== '0)
    begin
      $display("dispatch stage did not go idle %s within %0d cycles", where, IDLE_TIMEOUT);
      $display("Regression failed");
      $fatal(1, "stage stuck with a valid instruction");
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    row_t held;
    logic flush_now;
    held       = '0;
    rst        = 1'b1;
    fill_regs();
    build_table();
    drive_row('0);
    idu_vld = 1'b1;  // reset must win over a waiting instruction

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst     = 1'b0;
    idu_vld = 1'b0;
    #2;
    check_val("dpu_vld", 32'(dpu_vld), 32'd0);
    check_val("issue_vld", 32'(issue_vld), 32'd0);
    wait_idle("after reset");

    foreach (rows[i])
    begin
      @(negedge clk);
      drive_row(rows[i]);
      #2;
      check_row(rows[i], held);
      flush_now = rows[i].exu[3] & (rows[i].exu[1] | rows[i].exu[0]);
      if (rows[i].vld && !(rows[i].exp_vld && rows[i].exp_freeze) && !flush_now)
      begin
        held = rows[i];  // taken at the coming edge
      end
    end
    wait_idle("at the end of the table");

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
